// File: design/nonogram_pkg.sv
`default_nettype none

package nonogram_pkg;

    localparam int BOARD_SIZE    = 4;  // default board side
    localparam int NUM_LANES_DEF = 3;  // default number of line filters
    localparam int SIZE_MAX      = 8;  // widest line a word can carry
    localparam int WORD_W        = 12; // flag + 11 payload bits

    typedef logic [$clog2(2*SIZE_MAX)-1:0] line_ind_t; // rows first, then columns
    typedef logic [6:0] option_cnt_t;

    // header view: which line, and how many options follow
    typedef struct packed {
        logic        flag;     // 1 for a header
        line_ind_t   line_ind;
        option_cnt_t count;
    } header_fields_t;

    // option view: bit i is cell i of the line
    typedef struct packed {
        logic                          flag; // 0 for an option
        logic [WORD_W-SIZE_MAX-2:0]    pad;
        logic [SIZE_MAX-1:0]           bits;
    } option_fields_t;

    // one queue word, decoded by its flag bit
    typedef union packed {
        header_fields_t hdr;
        option_fields_t opt;
    } queue_word_t;

    // flat board position of cell pos on a line
    // columns sit above the rows and are transposed
    function automatic int cell_idx(input int size, input line_ind_t line, input int pos);
        if (int'(line) < size) begin
            return int'(line) * size + pos;      // row
        end
        return pos * size + (int'(line) - size); // column
    endfunction

endpackage

`default_nettype wire

// File: design/line_job_if.sv
`timescale 1ns/10ps
`default_nettype none

// dispatcher to filter, one word per four-phase cycle
interface line_job_if;
    import nonogram_pkg::*;

    logic        req;
    logic        ack;
    queue_word_t word;
    logic        busy; // filter owns a line, header seen, summary not yet handed over

    modport master (
        output req,
        output word,
        input  ack,
        input  busy
    );

    modport slave (
        input  req,
        input  word,
        output ack,
        output busy
    );

endinterface

`default_nettype wire

// File: design/line_result_if.sv
`timescale 1ns/10ps
`default_nettype none

// filter to merger: survivors, then the line summary with last set
interface line_result_if;
    import nonogram_pkg::*;

    logic                req;
    logic                ack;
    queue_word_t         word;        // survivor, or new header when last
    logic                last;
    logic [SIZE_MAX-1:0] known_mask;  // forced cells of the line
    logic [SIZE_MAX-1:0] assign_bits; // their values

    modport master (
        output req,
        output word,
        output last,
        output known_mask,
        output assign_bits,
        input  ack
    );

    modport slave (
        input  req,
        input  word,
        input  last,
        input  known_mask,
        input  assign_bits,
        output ack
    );

endinterface

`default_nettype wire

// File: design/option_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module option_dispatcher #(
    parameter int NUM_LANES = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_req,
    output logic                     in_ack,
    input  nonogram_pkg::queue_word_t in_word,
    line_job_if.master               jobs [NUM_LANES]
);
    import nonogram_pkg::*;

    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] busy_v;
    logic [NUM_LANES-1:0] ack_v;
    logic [LW-1:0]        free_lane; // lowest idle filter
    logic                 free_ok;
    logic [LW-1:0]        lane_sel;  // lane that owns the current line
    logic                 lane_req;
    logic                 active;    // a word is in flight on either side
    logic                 take;
    option_cnt_t          owed;      // options still due to lane_sel
    queue_word_t          buf_word;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign busy_v[g]    = jobs[g].busy;
        assign ack_v[g]     = jobs[g].ack;
        assign jobs[g].req  = lane_req && (lane_sel == LW'(g));
        assign jobs[g].word = buf_word;
    end

    always_comb begin
        free_ok   = 1'b0;
        free_lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin // downward so lowest wins
            if (!busy_v[i]) begin
                free_ok   = 1'b1;
                free_lane = LW'(i);
            end
        end
    end

    // a header waits for a free lane, an option goes straight to its owner
    assign take = !active && in_req && (!in_word.hdr.flag || free_ok);

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            in_ack   <= 1'b0;
            lane_req <= 1'b0;
            lane_sel <= '0;
            owed     <= '0;
        end else if (take) begin
            active   <= 1'b1;
            in_ack   <= 1'b1;          // ack one cycle after in_req
            lane_req <= 1'b1;
            buf_word <= in_word;
            if (in_word.hdr.flag) begin
                lane_sel <= free_lane; // new line, new owner
                owed     <= in_word.hdr.count;
            end else begin
                owed <= owed - 1'b1;
            end
        end else if (active) begin
            if (in_ack && !in_req) in_ack <= 1'b0;
            if (lane_req && ack_v[lane_sel]) lane_req <= 1'b0;
            // done once both four-phase cycles are back to zero
            if (!in_ack && !lane_req && !ack_v[lane_sel]) active <= 1'b0;
        end
    end

    // the feeder must not send more options than the header promised
    a_no_stray_option: assert property (@(posedge clk) disable iff (rst)
        (!active && in_req && !in_word.hdr.flag) |-> (owed != '0));

endmodule

`default_nettype wire

// File: design/line_filter.sv
`timescale 1ns/10ps
`default_nettype none

module line_filter #(
    parameter int SIZE = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    line_job_if.slave            job,
    line_result_if.master        res,
    input  logic [SIZE*SIZE-1:0] board_known,
    input  logic [SIZE*SIZE-1:0] board_assigned
);
    import nonogram_pkg::*;

    localparam logic [2:0] ST_IDLE  = 3'd0; // waiting for a job word
    localparam logic [2:0] ST_CHECK = 3'd1; // register the contradiction check
    localparam logic [2:0] ST_EVAL  = 3'd2; // forward or drop
    localparam logic [2:0] ST_SUM   = 3'd3; // emit the header with summary
    localparam logic [2:0] ST_RES   = 3'd4; // result four-phase in progress

    logic [2:0]      state;
    queue_word_t     job_w;
    line_ind_t       line_r;
    option_cnt_t     cnt_r;   // count from the header
    option_cnt_t     left;    // options not yet received
    option_cnt_t     surv;    // survivors so far
    logic [SIZE-1:0] always1;
    logic [SIZE-1:0] always0;
    logic [SIZE-1:0] line_known;
    logic [SIZE-1:0] line_assigned;
    logic [SIZE-1:0] opt_bits;
    logic            keep;

    // pull the current line out of the board, columns transposed
    always_comb begin
        line_known    = '0;
        line_assigned = '0;
        for (int i = 0; i < SIZE; i++) begin
            line_known[i]    = board_known[cell_idx(SIZE, line_r, i)];
            line_assigned[i] = board_assigned[cell_idx(SIZE, line_r, i)];
        end
    end

    assign opt_bits = job_w.opt.bits[SIZE-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            job.ack  <= 1'b0;
            job.busy <= 1'b0;
            res.req  <= 1'b0;
            res.last <= 1'b0;
        end else begin
            if (job.ack && !job.req) job.ack <= 1'b0;
            case (state)
                ST_IDLE: if (job.req && !job.ack) begin
                    job.ack <= 1'b1;
                    job_w   <= job.word;
                    if (job.word.hdr.flag) begin
                        job.busy <= 1'b1;
                        line_r   <= job.word.hdr.line_ind;
                        cnt_r    <= job.word.hdr.count;
                        left     <= job.word.hdr.count;
                        surv     <= '0;
                        always1  <= '1;
                        always0  <= '1;
                        state    <= (job.word.hdr.count == '0) ? ST_SUM : ST_IDLE;
                    end else begin
                        left  <= left - 1'b1;
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    // contradiction: differs from a known cell
                    keep  <= ~|((opt_bits ^ line_assigned) & line_known);
                    state <= ST_EVAL;
                end
                ST_EVAL: if (keep) begin
                    res.req  <= 1'b1;
                    res.last <= 1'b0;
                    res.word <= job_w;
                    always1  <= always1 & opt_bits;
                    always0  <= always0 & ~opt_bits;
                    surv     <= surv + 1'b1;
                    state    <= ST_RES;
                end else begin
                    state <= (left == '0) ? ST_SUM : ST_IDLE; // dropped silently
                end
                ST_SUM: begin
                    res.req     <= 1'b1;
                    res.last    <= 1'b1;
                    res.word.hdr <= '{flag: 1'b1, line_ind: line_r, count: surv};
                    // no survivors means nothing can be forced
                    res.known_mask  <= (surv == '0) ? '0 : SIZE_MAX'(always1 | always0);
                    res.assign_bits <= SIZE_MAX'(always1);
                    state       <= ST_RES;
                end
                ST_RES: if (res.req && res.ack) begin
                    res.req <= 1'b0;
                end else if (!res.req && !res.ack) begin
                    if (res.last) begin
                        job.busy <= 1'b0; // summary handed over, lane free
                        state    <= ST_IDLE;
                    end else begin
                        state <= (left == '0) ? ST_SUM : ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_surv_le_count: assert property (@(posedge clk) disable iff (rst)
        (state != ST_IDLE || job.busy) |-> (surv <= cnt_r));

endmodule

`default_nettype wire

// File: design/board_merger.sv
`timescale 1ns/10ps
`default_nettype none

module board_merger #(
    parameter int SIZE      = 4,
    parameter int NUM_LANES = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    line_result_if.slave              results [NUM_LANES],
    output logic                      out_req,
    input  logic                      out_ack,
    output nonogram_pkg::queue_word_t out_word,
    output logic [SIZE*SIZE-1:0]      known,
    output logic [SIZE*SIZE-1:0]      assigned,
    output logic                      solved
);
    import nonogram_pkg::*;

    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    localparam logic [1:0] M_IDLE  = 2'd0;
    localparam logic [1:0] M_OUT   = 2'd1; // out_req up, waiting for out_ack
    localparam logic [1:0] M_DRAIN = 2'd2; // waiting for out_ack to fall
    localparam logic [1:0] M_ACK   = 2'd3; // lane ack up, waiting for lane req to fall

    logic [1:0]           state;
    logic                 locked;  // stay on one lane until its header passes
    logic [LW-1:0]        sel;
    logic [LW-1:0]        pick;
    logic                 any_req;
    logic                 lane_ack;
    logic                 w_last;
    logic [SIZE_MAX-1:0]  w_km;
    logic [SIZE_MAX-1:0]  w_ab;
    logic                 apply;
    logic [SIZE-1:0]      conflict;
    logic [NUM_LANES-1:0] req_v;
    logic [NUM_LANES-1:0] last_v;
    queue_word_t          word_v [NUM_LANES];
    logic [SIZE_MAX-1:0]  km_v   [NUM_LANES];
    logic [SIZE_MAX-1:0]  ab_v   [NUM_LANES];

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign req_v[g]       = results[g].req;
        assign last_v[g]      = results[g].last;
        assign word_v[g]      = results[g].word;
        assign km_v[g]        = results[g].known_mask;
        assign ab_v[g]        = results[g].assign_bits;
        assign results[g].ack = lane_ack && (sel == LW'(g));
    end

    always_comb begin
        pick    = sel;
        any_req = req_v[sel];
        if (!locked) begin
            any_req = |req_v;
            pick    = '0;
            for (int i = NUM_LANES - 1; i >= 0; i--) begin
                if (req_v[i]) pick = LW'(i); // lowest requester
            end
        end
    end

    // board write happens on the edge that acks the header
    assign apply = (state == M_DRAIN) && !out_ack && w_last;

    always_comb begin
        conflict = '0;
        for (int i = 0; i < SIZE; i++) begin
            conflict[i] = w_km[i] && known[cell_idx(SIZE, out_word.hdr.line_ind, i)]
                && (assigned[cell_idx(SIZE, out_word.hdr.line_ind, i)] != w_ab[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= M_IDLE;
            locked   <= 1'b0;
            sel      <= '0;
            out_req  <= 1'b0;
            lane_ack <= 1'b0;
            known    <= '0;
            assigned <= '0;
            solved   <= 1'b0;
        end else begin
            solved <= &known; // known never clears, so this sticks
            case (state)
                M_IDLE: if (any_req) begin
                    sel      <= pick;
                    locked   <= 1'b1;
                    out_word <= word_v[pick];
                    w_last   <= last_v[pick];
                    w_km     <= km_v[pick];
                    w_ab     <= ab_v[pick];
                    out_req  <= 1'b1;
                    state    <= M_OUT;
                end
                M_OUT: if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= M_DRAIN;
                end
                M_DRAIN: if (!out_ack) begin
                    lane_ack <= 1'b1; // only now release the lane word
                    state    <= M_ACK;
                    if (apply) begin
                        locked <= 1'b0;
                        for (int i = 0; i < SIZE; i++) begin
                            if (w_km[i]) begin
                                known[cell_idx(SIZE, out_word.hdr.line_ind, i)]    <= 1'b1;
                                assigned[cell_idx(SIZE, out_word.hdr.line_ind, i)] <= w_ab[i];
                            end
                        end
                    end
                end
                default: if (!req_v[sel]) begin // M_ACK
                    lane_ack <= 1'b0;
                    state    <= M_IDLE;
                end
            endcase
        end
    end

    // a filter summary must agree with what the board already holds
    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        apply |-> (conflict == '0));

endmodule

`default_nettype wire

// File: design/nonogram_solver_top.sv
`timescale 1ns/10ps
`default_nettype none

module nonogram_solver_top #(
    parameter int SIZE      = nonogram_pkg::BOARD_SIZE,
    parameter int NUM_LANES = nonogram_pkg::NUM_LANES_DEF
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_req,
    output logic                      in_ack,
    input  nonogram_pkg::queue_word_t in_word,
    output logic                      out_req,
    input  logic                      out_ack,
    output nonogram_pkg::queue_word_t out_word,
    output logic [SIZE*SIZE-1:0]      known,
    output logic [SIZE*SIZE-1:0]      assigned,
    output logic                      solved
);

    line_job_if    jobs    [NUM_LANES] ();
    line_result_if results [NUM_LANES] ();

    option_dispatcher #(
        .NUM_LANES(NUM_LANES)
    ) u_option_dispatcher (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .in_word (in_word),
        .jobs    (jobs)
    );

    // filters all read the same board, each owns one line at a time
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_filter
        line_filter #(
            .SIZE(SIZE)
        ) u_line_filter (
            .clk            (clk),
            .rst            (rst),
            .job            (jobs[g]),
            .res            (results[g]),
            .board_known    (known),
            .board_assigned (assigned)
        );
    end

    board_merger #(
        .SIZE      (SIZE),
        .NUM_LANES (NUM_LANES)
    ) u_board_merger (
        .clk      (clk),
        .rst      (rst),
        .results  (results),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_word (out_word),
        .known    (known),
        .assigned (assigned),
        .solved   (solved)
    );

endmodule

`default_nettype wire

// File: tests/tb_board_model.svh
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// reference model of the board
// SIZE comes from the including module
// rows are lines 0..SIZE-1 and columns are SIZE..2*SIZE-1

// cells of one line with bit i as cell i
function automatic logic [SIZE-1:0] line_cells(input logic [SIZE*SIZE-1:0] board,
                                               input int line);
    logic [SIZE-1:0] cells;
    cells = '0;
    for (int i = 0; i < SIZE; i++) begin
        if (line < SIZE) begin
            cells[i] = board[line*SIZE + i];         // row r holds cells r*SIZE..
        end else begin
            cells[i] = board[i*SIZE + (line - SIZE)]; // column reads down the rows
        end
    end
    return cells;
endfunction

// an option survives when it agrees with every known cell
function automatic bit fits_line(input logic [SIZE-1:0] opt, input logic [SIZE-1:0] kn,
                                 input logic [SIZE-1:0] av);
    return ((opt ^ av) & kn) == '0;
endfunction

// cells fixed by the survivors as always one or always zero
function automatic logic [SIZE-1:0] forced_mask(input logic [SIZE-1:0] ones,
                                                input logic [SIZE-1:0] zeros, input int n);
    if (n == 0) return '0; // no survivors so nothing learned
    return ones | zeros;
endfunction

// write vals into the selected cells of one line
function automatic logic [SIZE*SIZE-1:0] set_cells(input logic [SIZE*SIZE-1:0] board,
        input int line, input logic [SIZE-1:0] sel, input logic [SIZE-1:0] vals);
    logic [SIZE*SIZE-1:0] nb;
    nb = board;
    for (int i = 0; i < SIZE; i++) begin
        if (sel[i] && line < SIZE) nb[line*SIZE + i] = vals[i];
        else if (sel[i]) nb[i*SIZE + (line - SIZE)] = vals[i]; // transposed
    end
    return nb;
endfunction

`endif

// File: tests/tb_nonogram_solver.sv
`timescale 1ns/10ps
`default_nettype none

module tb_nonogram_solver;
    import nonogram_pkg::*;

    localparam int SIZE      = 4;
    localparam int NUM_LANES = 3;
    localparam int MAX_WORDS = 4 * SIZE * 6;     // 4 rounds, header + up to 5 options each
    localparam int WATCH_CYC = 200 * MAX_WORDS;

    `include "tb_board_model.svh"

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_req;
    logic                 in_ack;
    queue_word_t          in_word;
    logic                 out_req;
    logic                 out_ack;
    queue_word_t          out_word;
    logic [SIZE*SIZE-1:0] known;
    logic [SIZE*SIZE-1:0] assigned;
    logic                 solved;

    // hidden solution, row r in bits r*SIZE +: SIZE
    logic [SIZE*SIZE-1:0] sol = {4'b0100, 4'b1011, 4'b0110, 4'b1101};
    int                   seed = 32'he891_4bb9;
    logic [SIZE*SIZE-1:0] mdl_known;
    logic [SIZE*SIZE-1:0] mdl_assigned;
    logic                 mdl_full;
    logic [SIZE-1:0]      cand [8];          // option list of the line being fed
    int                   cand_n;
    logic [SIZE-1:0]      exp_opt [2*SIZE][8]; // expected survivors per line
    int                   exp_n [2*SIZE];
    logic [SIZE-1:0]      exp_mask [2*SIZE];
    logic [SIZE-1:0]      exp_vals [2*SIZE];
    bit                   hdr_due [2*SIZE];  // header still owed for this line
    logic [SIZE-1:0]      pend [$];          // survivors seen since the last header
    int                   hdr_seen;
    int                   errors;
    int                   ntests;
    int                   nfailed;
    int                   err_mark;
    string                test_name;

    assign mdl_full = &mdl_known;

    nonogram_solver_top #(
        .SIZE      (SIZE),
        .NUM_LANES (NUM_LANES)
    ) u_nonogram_solver_top (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_word  (in_word),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_word (out_word),
        .known    (known),
        .assigned (assigned),
        .solved   (solved)
    );

    always #5 clk = ~clk; // 10 ns period

    task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, got);
        errors++;
    endtask

    task automatic fail_check(input string msg);
        $display("ERROR %s", msg);
        errors++;
    endtask

    // sticky flag, and never ahead of the model
    a_solved_sticks: assert property (@(posedge clk) disable iff (rst) solved |=> solved)
        else fail_check("solved fell after it had risen");
    a_solved_early: assert property (@(posedge clk) disable iff (rst) solved |-> mdl_full)
        else fail_check("solved rose while the model board still had unknown cells");
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_req && $past(out_req)) |-> $stable(out_word))
        else fail_check("out_word changed while out_req was held high");

    // one four-phase transfer on the input side
    task automatic send_word(input queue_word_t w);
        @(negedge clk);
        in_word = w;
        in_req  = 1'b1;
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    // true pattern, alone or hidden among random decoys
    task automatic build_list(input int line, input bit single);
        int tpos;
        logic [SIZE-1:0] truth;
        truth = line_cells(sol, line);
        if (single) begin
            cand_n  = 1;
            cand[0] = truth;
        end else begin
            cand_n = 2 + ($random(seed) & 3);
            tpos   = ($random(seed) & 'h7fff) % cand_n;
            for (int k = 0; k < cand_n; k++) begin
                cand[k] = (k == tpos) ? truth : SIZE'($random(seed));
            end
        end
    endtask

    // expected result from the model board, then the words themselves
    task automatic feed_line(input int line);
        logic [SIZE-1:0] kn;
        logic [SIZE-1:0] av;
        logic [SIZE-1:0] ones;
        logic [SIZE-1:0] zeros;
        queue_word_t w;
        kn    = line_cells(mdl_known, line);
        av    = line_cells(mdl_assigned, line);
        ones  = '1;
        zeros = '1;
        exp_n[line] = 0;
        for (int k = 0; k < cand_n; k++) begin
            if (fits_line(cand[k], kn, av)) begin
                exp_opt[line][exp_n[line]] = cand[k];
                exp_n[line]++;
                ones  = ones & cand[k];
                zeros = zeros & ~cand[k];
            end
        end
        exp_mask[line] = forced_mask(ones, zeros, exp_n[line]);
        exp_vals[line] = ones;
        hdr_due[line]  = 1'b1;
        w = '0;
        w.hdr.flag     = 1'b1;
        w.hdr.line_ind = line_ind_t'(line);
        w.hdr.count    = option_cnt_t'(cand_n);
        send_word(w);
        for (int k = 0; k < cand_n; k++) begin
            w = '0;                       // flag low marks an option
            w.opt.bits[SIZE-1:0] = cand[k];
            send_word(w);
        end
    endtask

    // scoreboard for one accepted output word
    task automatic take_output(input queue_word_t w);
        int ln;
        int n;
        if (!w.hdr.flag) begin
            pend.push_back(w.opt.bits[SIZE-1:0]);
        end else begin
            ln = int'(w.hdr.line_ind);
            n  = pend.size();
            if (ln >= 2*SIZE || !hdr_due[ln]) begin
                fail_check($sformatf("header for line %0d came out unexpected", ln));
            end else begin
                hdr_due[ln] = 1'b0;
                assert (w.hdr.count == option_cnt_t'(exp_n[ln]))
                    else log_mismatch("out_word.hdr.count", exp_n[ln], w.hdr.count);
                assert (n == exp_n[ln])
                    else fail_check($sformatf("line %0d gave %0d survivors, %0d expected",
                                              ln, n, exp_n[ln]));
                for (int i = 0; i < n && i < exp_n[ln]; i++) begin
                    assert (pend[i] == exp_opt[ln][i])
                        else log_mismatch($sformatf("out_word.opt.bits line %0d #%0d", ln, i),
                                          exp_opt[ln][i], pend[i]);
                end
                mdl_known    = set_cells(mdl_known, ln, exp_mask[ln], exp_mask[ln]);
                mdl_assigned = set_cells(mdl_assigned, ln, exp_mask[ln], exp_vals[ln]);
                hdr_seen++;
            end
            pend.delete();
        end
    endtask

    // output side: random ack delay, then full four-phase
    initial begin : out_side
        int gap;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && out_req && !out_ack) begin
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clk);
                take_output(out_word);
                out_ack = 1'b1;
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    task automatic check_board();
        assert (known == mdl_known) else log_mismatch("known", mdl_known, known);
        assert (assigned == mdl_assigned) else log_mismatch("assigned", mdl_assigned, assigned);
        assert (solved == mdl_full) else log_mismatch("solved", mdl_full, solved);
        assert (pend.size() == 0)
            else fail_check("survivors came out with no header after them");
    endtask

    // SIZE parallel lines of one kind, so no line reads another's cells
    task automatic run_round(input int first, input logic [SIZE-1:0] single);
        hdr_seen = 0;
        for (int l = 0; l < SIZE; l++) begin
            build_list(first + l, single[l]);
            feed_line(first + l);
        end
        while (hdr_seen < SIZE) @(negedge clk);
        repeat (4) @(negedge clk); // last board write, then solved
        check_board();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
        ntests++;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - err_mark);
            nfailed++;
        end
    endtask

    initial begin : watchdog
        repeat (WATCH_CYC) @(posedge clk);
        $display("watchdog: run still busy after %0d cycles", WATCH_CYC);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        rst          = 1'b1;
        in_req       = 1'b0;
        in_word      = '0;
        mdl_known    = '0;
        mdl_assigned = '0;
        errors       = 0;
        ntests       = 0;
        nfailed      = 0;
        for (int l = 0; l < 2*SIZE; l++) hdr_due[l] = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("row_pass");                  // row 0 has a single option
        run_round(0, 4'b0001);
        assert (line_cells(known, 0) == '1) else log_mismatch("known row 0", 'hf,
                                                             line_cells(known, 0));
        assert (line_cells(assigned, 0) == line_cells(sol, 0))
            else log_mismatch("assigned row 0", line_cells(sol, 0), line_cells(assigned, 0));
        end_test();

        begin_test("column_pass");               // decoys now hit known cells
        run_round(SIZE, 4'b0000);
        end_test();

        begin_test("row_repeat");
        run_round(0, 4'b0000);
        end_test();

        begin_test("column_finish");             // every column pinned, board complete
        run_round(SIZE, 4'b1111);
        assert (solved == 1'b1) else log_mismatch("solved", 1, solved);
        assert (assigned == sol) else log_mismatch("assigned", sol, assigned);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", ntests, nfailed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tests
design/nonogram_pkg.sv
design/line_job_if.sv
design/line_result_if.sv
design/option_dispatcher.sv
design/line_filter.sv
design/board_merger.sv
design/nonogram_solver_top.sv
tests/tb_nonogram_solver.sv

// File: run.sh
#!/usr/bin/env bash
# build the nonogram solver testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_nonogram_solver
BUILD=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module "$TOP" -Mdir "$BUILD" -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$("$BUILD/sim" 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
